// File: tb.f
+incdir+hw
hw/mem_bus_pkg.sv
hw/cpu_pkg.sv
hw/cpu_memory_interface.sv
hw/banked_memory.sv
hw/memory_writeback.sv
hw/slurm_mem_top.sv
tb/tb_slurm_mem.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_slurm_mem
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF "*** PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/tb_slurm_mem.sv
/*
 * Testbench for the slurm16 memory subsystem
 * Plays the pipeline with stores, loads, fetches and a halt/wake cycle,
 * and checks every strobe against a shadow memory model
 */

`timescale 1ns/1ps
`default_nettype none

`include "slurm_params.svh"

module tb_slurm_mem;

	import cpu_pkg::*;

	localparam int N_WORDS     = 12;	// Full word stores with even entries in bank 0
	localparam int N_PARTIAL   = 8;
	localparam int N_LOADS     = 20;
	localparam int N_FETCH     = 8;
	localparam int N_OPS       = 1 + N_WORDS + N_PARTIAL + N_LOADS + N_FETCH + 1;
	localparam int CYCLE_LIMIT = 40 * N_OPS;
	localparam logic [15:0] HOME = 16'h0000;	// Idle pc between memory operations

	logic                             CLK;
	logic                             RSTb;
	cpu_cmd_t                         cmd;
	logic                             is_executing;
	logic                             is_fetching;
	logic [`SLURM_BITS - 1:0]         instr;
	logic                             instr_strobe;
	logic [`SLURM_BITS - 1:0]         load_data;
	logic                             load_strobe;
	logic [`SLURM_ADDRESS_BITS - 1:0] link_address;
	logic                             bus_valid;
	logic                             bus_wr;

	logic [31:0] lfsr = 32'd66959;
	logic [15:0] shadow [512];		// One entry per implemented word with the bank bit on top
	bit          written [512];		// Word holds a fully known value
	bit          used_pc [65536];	// Addresses ever driven as pc
	logic [15:0] addr_list [N_WORDS];
	logic [15:0] exp_addr;
	logic [1:0]  exp_mask;
	logic        load_active = 1'b0;
	logic        fetch_slot = 1'b0;	// Set when the slot after the last rising edge must fetch
	int          cycle_count = 0;

	slurm_mem_top UUT (
		.CLK          (CLK),
		.RSTb         (RSTb),
		.cmd          (cmd),
		.is_executing (is_executing),
		.is_fetching  (is_fetching),
		.instr        (instr),
		.instr_strobe (instr_strobe),
		.load_data    (load_data),
		.load_strobe  (load_strobe),
		.link_address (link_address),
		.bus_valid    (bus_valid),
		.bus_wr       (bus_wr)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[0]};	// One step per bit taken
		end
	endtask

	// Bank bit and the word index that the RAM decodes
	function automatic logic [8:0] word_index(input logic [15:0] addr);
		return {addr[15], addr[8:1]};
	endfunction

	// Expected load result where single byte masks zero-extend
	function automatic logic [15:0] load_expect(input logic [15:0] word, input logic [1:0] mask);
		logic [15:0] r;
		case (mask)
			2'b01:   r = {8'h00, word[7:0]};
			2'b10:   r = {8'h00, word[15:8]};
			default: r = word;
		endcase
		return r;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [15:0] actual,
			input logic [15:0] expected);
		if (actual !== expected)
			fail_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, actual, expected));
	endtask

	always @(posedge CLK) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
			fail_run("Timeout: the tests took longer than the cycle limit");
	end

	// The fetch flag announces the slot that follows this rising edge
	always @(posedge CLK)
		fetch_slot <= RSTb && is_fetching;

	// Strobes and bus levels are sampled mid-cycle where they are stable
	always @(negedge CLK) begin : compare
		logic [15:0] fpc;
		if (RSTb) begin
			if (fetch_slot && !(is_executing && !bus_wr))
				fail_run("is_fetching announced a fetch slot that did not follow");
			if (!fetch_slot && is_executing && !bus_wr && !load_active)
				fail_run("A fetch went on the bus without is_fetching before it");
			if (instr_strobe) begin
				fpc = link_address - 16'd2;	// Link is the fetch address plus two
				if (!used_pc[fpc])
					fail_run("A fetch came back for an address never driven as pc");
				if (written[word_index(fpc)])
					check_value("instr", instr, shadow[word_index(fpc)]);
			end
			if (load_strobe) begin
				if (!load_active)
					fail_run("A load strobe came while no load was in progress");
				check_value("load_data", load_data,
					load_expect(shadow[word_index(exp_addr)], exp_mask));
			end
		end
	end

	task automatic set_idle(input logic [15:0] pc);
		used_pc[pc] = 1'b1;
		cmd.load    = 1'b0;
		cmd.store   = 1'b0;
		cmd.halt    = 1'b0;
		cmd.wake    = 1'b0;
		cmd.pc      = pc;
	endtask

	// Waits until repeated loads and stores have left the pipeline
	task automatic wait_quiet();
		int quiet;
		quiet = 0;
		while (quiet < 4) begin
			@(negedge CLK);
			if (load_strobe || bus_wr)
				quiet = 0;
			else
				quiet = quiet + 1;
		end
	endtask

	task automatic require_wait_state(input logic bank_a, input logic bank_b,
			input logic saw_idle);
		if (bank_a != bank_b && !saw_idle)
			fail_run("A bank switch went through without a wait state");
	endtask

	task automatic store_to(input logic [15:0] addr, input logic [15:0] data,
			input logic [1:0] mask);
		logic        saw_idle;
		logic        done;
		logic [15:0] w;
		saw_idle = 1'b0;
		done     = 1'b0;
		cmd.store      = 1'b1;
		cmd.ls_address = addr;
		cmd.store_data = data;
		cmd.store_mask = mask;
		while (!done) begin
			@(negedge CLK);
			if (!is_executing)
				saw_idle = 1'b1;
			if (bus_valid && bus_wr && UUT.u_mem.resp.ready)
				done = 1'b1;	// Drops the accepted write before the next slot
		end
		set_idle(HOME);
		wait_quiet();
		w = shadow[word_index(addr)];
		if (mask[0])
			w[7:0] = data[7:0];
		if (mask[1])
			w[15:8] = data[15:8];
		shadow[word_index(addr)] = w;
		if (mask == 2'b11)
			written[word_index(addr)] = 1'b1;
		require_wait_state(addr[15], HOME[15], saw_idle);
	endtask

	task automatic load_from(input logic [15:0] addr, input logic [1:0] mask);
		logic saw_idle;
		saw_idle    = 1'b0;
		exp_addr    = addr;
		exp_mask    = mask;
		load_active = 1'b1;
		cmd.load       = 1'b1;
		cmd.ls_address = addr;
		cmd.store_mask = mask;
		do begin
			@(negedge CLK);
			if (!is_executing)
				saw_idle = 1'b1;
		end while (!load_strobe);
		set_idle(HOME);
		wait_quiet();	// Repeated loads of the same word are checked too
		load_active = 1'b0;
		require_wait_state(addr[15], HOME[15], saw_idle);
	endtask

	task automatic fetch_from(input logic [15:0] pc, input logic [15:0] prev_pc);
		logic saw_idle;
		saw_idle = 1'b0;
		set_idle(pc);
		do begin
			@(negedge CLK);
			if (!is_executing)
				saw_idle = 1'b1;
		end while (!(instr_strobe && link_address == pc + 16'd2));
		require_wait_state(pc[15], prev_pc[15], saw_idle);
	endtask

	task automatic halt_then_wake(input logic [15:0] pc);
		logic [15:0] r;
		cmd.halt = 1'b1;
		do
			@(negedge CLK);
		while (is_executing);
		cmd.halt = 1'b0;
		rand_bits(4, r);
		for (int i = 0; i < r + 4; i++) begin
			check_value("is_executing", {15'd0, is_executing}, 16'd0);
			check_value("bus_valid", {15'd0, bus_valid}, 16'd0);
			@(negedge CLK);
		end
		cmd.wake = 1'b1;
		do
			@(negedge CLK);
		while (!is_executing);
		cmd.wake = 1'b0;
		do
			@(negedge CLK);
		while (!(instr_strobe && link_address == pc + 16'd2));	// Fetching resumed at pc
	endtask

	initial begin : stimulus
		logic [15:0] r;
		logic [15:0] d;
		logic [15:0] prev_pc;
		logic [1:0]  m;
		int          j;
		RSTb           = 1'b0;
		cmd            = '0;
		cmd.store_mask = 2'b11;
		used_pc[0]     = 1'b1;	// Address register resets to zero
		set_idle(HOME);
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		RSTb = 1'b1;

		// Nothing reaches the bus until the reset wait states are done
		while (!is_executing) begin
			check_value("bus_valid", {15'd0, bus_valid}, 16'd0);
			check_value("bus_wr", {15'd0, bus_wr}, 16'd0);
			check_value("instr_strobe", {15'd0, instr_strobe}, 16'd0);
			check_value("load_strobe", {15'd0, load_strobe}, 16'd0);
			@(negedge CLK);
		end

		rand_bits(16, d);
		store_to(HOME, d, 2'b11);
		for (int i = 0; i < N_WORDS; i++) begin
			rand_bits(8, r);
			if (i % 2 == 0 && r[7:0] == 8'd0)
				r[7:0] = 8'd1;	// Keeps the home word out of the list
			addr_list[i] = {i[0], 6'd0, r[7:0], 1'b0};
			rand_bits(16, d);
			store_to(addr_list[i], d, 2'b11);
		end
		for (int i = 0; i < N_PARTIAL; i++) begin
			rand_bits(4, r);
			j = (r % (N_WORDS / 2)) * 2 + i % 2;
			rand_bits(16, d);
			m = i[0] ? 2'b10 : 2'b01;
			store_to(addr_list[j], d, m);
		end

		// Loads alternate between the banks
		for (int i = 0; i < N_LOADS; i++) begin
			rand_bits(4, r);
			j = (r % (N_WORDS / 2)) * 2 + i % 2;
			rand_bits(2, d);
			m = (d[1:0] == 2'b00) ? 2'b11 : d[1:0];
			load_from(addr_list[j], m);
		end

		prev_pc = HOME;
		for (int i = 0; i < N_FETCH; i++) begin
			rand_bits(4, r);
			j = (r % (N_WORDS / 2)) * 2 + i % 2;
			fetch_from(addr_list[j], prev_pc);
			prev_pc = addr_list[j];
		end

		halt_then_wake(prev_pc);

		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/slurm_mem_top.sv
/*
 * slurm16 memory subsystem top
 * CPU memory interface, banked RAM and write back wired together
 */

`timescale 1ns/1ps
`default_nettype none

`include "slurm_params.svh"

module slurm_mem_top (
	input  wire                               CLK,
	input  wire                               RSTb,
	input  wire cpu_pkg::cpu_cmd_t            cmd,
	output logic                              is_executing,
	output logic                              is_fetching,
	output logic [`SLURM_BITS - 1:0]          instr,
	output logic                              instr_strobe,
	output logic [`SLURM_BITS - 1:0]          load_data,
	output logic                              load_strobe,
	output logic [`SLURM_ADDRESS_BITS - 1:0]  link_address,
	output logic                              bus_valid,
	output logic                              bus_wr
);

	import mem_bus_pkg::*;

	mem_req_t                         req;
	mem_resp_t                        resp;
	logic                             is_instruction;
	logic                             rd_pending;
	logic [1:0]                       wr_mask_delayed;
	logic [`SLURM_ADDRESS_BITS - 1:0] ret_address;

	assign rd_pending = req.valid && resp.ready && !req.wr;	// Accepted read this cycle
	assign bus_valid  = req.valid;
	assign bus_wr     = req.wr;

	cpu_memory_interface u_cpu_mem (
		.CLK             (CLK),
		.RSTb            (RSTb),
		.cmd             (cmd),
		.resp_ready      (resp.ready),
		.req             (req),
		.is_executing    (is_executing),
		.is_fetching     (is_fetching),
		.is_instruction  (is_instruction),
		.ret_address     (ret_address),
		.wr_mask_delayed (wr_mask_delayed)
	);

	banked_memory u_mem (
		.CLK  (CLK),
		.RSTb (RSTb),
		.req  (req),
		.resp (resp)
	);

	memory_writeback u_wb (
		.CLK             (CLK),
		.RSTb            (RSTb),
		.mem_data        (resp.data),
		.is_instruction  (is_instruction),
		.rd_pending      (rd_pending),
		.wr_mask_delayed (wr_mask_delayed),
		.ret_address     (ret_address),
		.instr           (instr),
		.instr_strobe    (instr_strobe),
		.load_data       (load_data),
		.load_strobe     (load_strobe),
		.link_address    (link_address)
	);

endmodule

`default_nettype wire

// File: hw/memory_writeback.sv
/*
 * slurm16 memory write back
 * Catches read data one cycle after an accepted read and routes it to
 * the instruction or load result, byte-selected by the delayed mask
 */

`timescale 1ns/1ps
`default_nettype none

`include "slurm_params.svh"

module memory_writeback (
	input  wire                               CLK,
	input  wire                               RSTb,
	input  wire [`SLURM_BITS - 1:0]           mem_data,
	input  wire                               is_instruction,
	input  wire                               rd_pending,
	input  wire [1:0]                         wr_mask_delayed,
	input  wire [`SLURM_ADDRESS_BITS - 1:0]   ret_address,
	output logic [`SLURM_BITS - 1:0]          instr,
	output logic                              instr_strobe,
	output logic [`SLURM_BITS - 1:0]          load_data,
	output logic                              load_strobe,
	output logic [`SLURM_ADDRESS_BITS - 1:0]  link_address
);

	localparam int B = `SLURM_BITS;

	logic         pending_r;		// Read accepted last cycle, data is on mem_data
	logic [B - 1:0] load_sel;

	// Single byte loads are zero-extended, anything else takes the full word
	always_comb begin
		case (wr_mask_delayed)
			2'b01:   load_sel = {{(B - 8){1'b0}}, mem_data[7:0]};
			2'b10:   load_sel = {{(B - 8){1'b0}}, mem_data[B - 1:B - 8]};
			default: load_sel = mem_data;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pending_r    <= 1'b0;
			instr        <= '0;
			instr_strobe <= 1'b0;
			load_data    <= '0;
			load_strobe  <= 1'b0;
			link_address <= '0;
		end else begin
			pending_r    <= rd_pending;
			instr_strobe <= pending_r && is_instruction;	// One-cycle pulses
			load_strobe  <= pending_r && !is_instruction;
			if (pending_r && is_instruction) begin
				instr        <= mem_data;
				link_address <= ret_address;			// Fetch address plus two
			end
			if (pending_r && !is_instruction)
				load_data <= load_sel;
		end
	end

endmodule

`default_nettype wire

// File: hw/banked_memory.sv
/*
 * slurm16 two-bank word RAM
 * Only the open bank is served; a request to the other bank opens it
 * for the next cycle. Byte-masked writes and one-cycle read latency
 */

`timescale 1ns/1ps
`default_nettype none

`include "slurm_params.svh"

module banked_memory (
	input  wire                          CLK,
	input  wire                          RSTb,
	input  wire mem_bus_pkg::mem_req_t   req,
	output mem_bus_pkg::mem_resp_t       resp
);

	localparam int IDX_BITS = $clog2(`SLURM_BANK_WORDS);
	localparam int BANK_BIT = `SLURM_ADDRESS_BITS - 2;	// Byte address MSB after the shift
	localparam int BYTES    = `SLURM_BITS / 8;

	logic [`SLURM_BITS - 1:0] bank0 [`SLURM_BANK_WORDS];
	logic [`SLURM_BITS - 1:0] bank1 [`SLURM_BANK_WORDS];
	logic [`SLURM_BITS - 1:0] rd_data_r;
	logic                     open_bank;
	logic                     req_bank;
	logic [IDX_BITS - 1:0]    idx;
	logic                     ready;
	logic                     accept;

	assign req_bank = req.address[BANK_BIT];
	assign idx      = req.address[IDX_BITS - 1:0];	// Upper word bits alias within a bank
	assign ready    = (req_bank == open_bank);		// Level, independent of valid
	assign accept   = req.valid && ready;

	always_comb begin
		resp.ready = ready;
		resp.data  = rd_data_r;
	end

	always_ff @(posedge CLK) begin
		if (!RSTb)
			open_bank <= 1'b0;
		else if (req.valid && !ready)
			open_bank <= req_bank;					// Costs this cycle, served from the next
	end

	always_ff @(posedge CLK) begin
		if (accept && req.wr) begin
			for (int b = 0; b < BYTES; b++) begin
				if (req.wr_mask[b]) begin
					if (req_bank)
						bank1[idx][b * 8 +: 8] <= req.data[b * 8 +: 8];
					else
						bank0[idx][b * 8 +: 8] <= req.data[b * 8 +: 8];
				end
			end
		end
		if (accept && !req.wr)
			rd_data_r <= req_bank ? bank1[idx] : bank0[idx];	// Whole word, lane select is downstream
	end

endmodule

`default_nettype wire

// File: hw/cpu_memory_interface.sv
/*
 * slurm16 CPU memory interface
 * Sequences fetches, loads and stores over one memory port and
 * inserts two wait states whenever an access crosses into the other bank
 */

`timescale 1ns/1ps
`default_nettype none

`include "slurm_params.svh"

module cpu_memory_interface (
	input  wire                               CLK,
	input  wire                               RSTb,
	input  wire cpu_pkg::cpu_cmd_t            cmd,
	input  wire                               resp_ready,
	output mem_bus_pkg::mem_req_t             req,
	output logic                              is_executing,
	output logic                              is_fetching,
	output logic                              is_instruction,
	output logic [`SLURM_ADDRESS_BITS - 1:0]  ret_address,
	output logic [1:0]                        wr_mask_delayed
);

	import cpu_pkg::*;

	localparam int                             A = `SLURM_ADDRESS_BITS;
	localparam logic [`SLURM_ADDRESS_BITS - 1:0] INSTR_STEP = 2;	// Bytes per instruction

	cpu_state_t              state_r;
	cpu_state_t              state_next;
	logic [A - 1:0]          addr_r;		// Byte address on the bus this cycle
	logic [A - 1:0]          prev_addr_r;	// Address of the last valid request
	logic [A - 1:0]          next_addr;
	logic [`SLURM_BITS - 1:0] data_r;
	logic [1:0]              mask_r;
	logic                    bank_switch;
	logic                    take_cmd;

	// The last valid request opened its bank, so a differing top bit means ready is low
	assign bank_switch = addr_r[A - 1] ^ prev_addr_r[A - 1];

	assign is_executing = state_r inside {st_execute, st_execute_load, st_execute_store};

	// A command is consumed only when the access on the bus goes through
	assign take_cmd = is_executing && !bank_switch;

	assign next_addr = (cmd.load || cmd.store) ? cmd.ls_address : cmd.pc;

	// Picks the slot that follows an accepted access
	function automatic cpu_state_t cmd_state(input cpu_cmd_t c);
		cpu_state_t s;
		if (c.halt)
			s = st_halt;
		else if (c.load)
			s = st_execute_load;
		else if (c.store)
			s = st_execute_store;
		else
			s = st_execute;
		return s;
	endfunction

	always_comb begin
		state_next = state_r;
		case (state_r)
			st_halt:
				if (cmd.wake)
					state_next = st_wait_ready1;	// Wake always goes through the wait states
			st_execute:
				state_next = bank_switch ? st_wait_ready1 : cmd_state(cmd);
			st_execute_load:
				state_next = bank_switch ? st_wait_load1 : cmd_state(cmd);
			st_execute_store:
				state_next = bank_switch ? st_wait_store1 : cmd_state(cmd);
			st_wait_ready1: state_next = st_wait_ready2;
			st_wait_load1:  state_next = st_wait_load2;
			st_wait_store1: state_next = st_wait_store2;
			st_wait_ready2:
				if (resp_ready)
					state_next = st_execute;	// Bank is open now, retry the fetch
			st_wait_load2:
				if (resp_ready)
					state_next = st_execute_load;
			st_wait_store2:
				if (resp_ready)
					state_next = st_execute_store;
			default: state_next = st_halt;
		endcase
	end

	// The pc logic advances when the next slot is a fetch
	assign is_fetching = (state_next == st_execute);

	always_comb begin
		req.address = {1'b0, addr_r[A - 1:1]};		// Byte to word address
		req.data    = data_r;
		req.wr_mask = mask_r;
		req.valid   = is_executing;					// Wait and halt states stay off the bus
		req.wr      = (state_r == st_execute_store);
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state_r         <= st_wait_ready1;
			addr_r          <= '0;
			prev_addr_r     <= '0;					// Matches bank 0 open after reset
			mask_r          <= 2'b11;
			wr_mask_delayed <= 2'b11;
			is_instruction  <= 1'b0;
		end else begin
			state_r <= state_next;
			if (req.valid)
				prev_addr_r <= addr_r;				// Tracks which bank the RAM has open
			if (take_cmd) begin
				addr_r          <= next_addr;		// Held across a bank switch
				mask_r          <= cmd.store_mask;
				wr_mask_delayed <= mask_r;			// Lines up with the returning read data
			end
			if (is_executing)
				is_instruction <= (state_r == st_execute);
		end
	end

	always_ff @(posedge CLK) begin
		if (take_cmd)
			data_r <= cmd.store_data;
		ret_address <= addr_r + INSTR_STEP;			// Return address of the word now on the bus
	end

endmodule

`default_nettype wire

// File: hw/cpu_pkg.sv
/*
 * slurm16 CPU side types
 * Command word from the pipeline and the memory interface FSM states
 */

`default_nettype none

`include "slurm_params.svh"

package cpu_pkg;

	// What the pipeline wants from memory in the next slot
	typedef struct packed {
		logic                             load;			// Load from ls_address next
		logic                             store;		// Store to ls_address next
		logic                             halt;			// Put the CPU to sleep
		logic                             wake;			// Leave the halt state
		logic [`SLURM_ADDRESS_BITS - 1:0] pc;			// Next instruction address
		logic [`SLURM_ADDRESS_BITS - 1:0] ls_address;	// Load or store byte address
		logic [`SLURM_BITS - 1:0]         store_data;	// Data for a store
		logic [1:0]                       store_mask;	// Byte lanes for load or store
	} cpu_cmd_t;

	// The *1 and *2 states are the bank switch penalty for each access kind
	typedef enum logic [3:0] {
		st_halt          = 4'd0,	// No fetches at all
		st_execute       = 4'd1,	// Fetching instructions
		st_wait_ready1   = 4'd2,	// First bank switch cycle before a fetch
		st_wait_ready2   = 4'd3,	// Waits for the new bank before a fetch
		st_execute_load  = 4'd4,	// Load on the bus
		st_wait_load1    = 4'd5,	// First bank switch cycle before a load
		st_wait_load2    = 4'd6,	// Waits for the new bank before a load
		st_execute_store = 4'd7,	// Store on the bus
		st_wait_store1   = 4'd8,	// First bank switch cycle before a store
		st_wait_store2   = 4'd9		// Waits for the new bank before a store
	} cpu_state_t;

endpackage

`default_nettype wire

// File: hw/mem_bus_pkg.sv
/*
 * slurm16 memory bus types
 * Request and response words between a bus master and the banked RAM
 */

`default_nettype none

`include "slurm_params.svh"

package mem_bus_pkg;

	// One request per cycle, accepted when valid and ready are both high
	typedef struct packed {
		logic [`SLURM_ADDRESS_BITS - 1:0] address;	// Word address, bank bit just below the MSB
		logic [`SLURM_BITS - 1:0]         data;		// Write data
		logic                             wr;		// High for a store
		logic [1:0]                       wr_mask;	// One enable per byte lane
		logic                             valid;	// Request present
	} mem_req_t;

	// Ready is a level, data belongs to the read accepted one cycle earlier
	typedef struct packed {
		logic                     ready;	// Request targets the open bank
		logic [`SLURM_BITS - 1:0] data;		// Registered read data
	} mem_resp_t;

endpackage

`default_nettype wire

// File: hw/slurm_params.svh
/*
 * slurm16 memory side global parameters
 * Word, address and bank sizes shared by the packages and the RTL
 */

`ifndef SLURM_PARAMS_SVH
`define SLURM_PARAMS_SVH

// Data word width in bits, two bytes per word
`define SLURM_BITS 16

// Byte address width; the top bit picks the memory bank
`define SLURM_ADDRESS_BITS 16

// Words implemented in each bank; only the low word-address bits index a bank
`define SLURM_BANK_WORDS 256

`endif
